/* hw/core_pkg.sv */
package core_pkg;

    localparam int XLEN     = 32;
    localparam int REG_AW   = 5;
    localparam int NUM_REGS = 32;

    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    typedef enum logic [2:0]
    {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS    // result is the immediate.
    } alu_op_e;

    typedef enum logic [2:0]
    {
        KIND_ALU,
        KIND_LOAD,
        KIND_STORE,
        KIND_BEQ,
        KIND_BNE,
        KIND_JAL
    } instr_kind_e;

    // one request on the shared bus.
    typedef struct packed
    {
        logic            we;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
    } mem_req_t;

    typedef struct packed
    {
        instr_kind_e       kind;
        alu_op_e           alu_op;
        logic              use_imm;
        logic [REG_AW-1:0] rd;
        logic [REG_AW-1:0] rs1;
        logic [REG_AW-1:0] rs2;
        logic [XLEN-1:0]   imm;
        logic              writes_rd;
    } dec_t;

endpackage

/* hw/mem_arbiter.sv */
module mem_arbiter
(
    input  logic                      i_clk,
    input  logic                      i_arst_n,
    input  logic                      i_f_req,
    input  core_pkg::mem_req_t        i_f_pkt,
    output logic                      o_f_ack,
    input  logic                      i_d_req,
    input  core_pkg::mem_req_t        i_d_pkt,
    output logic                      o_d_ack,
    output logic [core_pkg::XLEN-1:0] o_rdata,
    output logic                      o_mem_req,
    output core_pkg::mem_req_t        o_mem,
    input  logic                      i_mem_ack,
    input  logic [core_pkg::XLEN-1:0] i_mem_rdata
);

    typedef enum logic [1:0]
    {
        ARB_IDLE,
        ARB_FETCH,
        ARB_DATA
    } arb_state_e;

    arb_state_e state_q;
    logic       f_grant;
    logic       d_grant;

    assign f_grant = (state_q == ARB_FETCH);
    assign d_grant = (state_q == ARB_DATA);

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            state_q <= ARB_IDLE;
        end
        else
        begin
            case (state_q)
                ARB_IDLE:
                begin
                    if (i_d_req)
                    begin
                        state_q <= ARB_DATA;    // data wins a tie.
                    end
                    else if (i_f_req)
                    begin
                        state_q <= ARB_FETCH;
                    end
                end
                ARB_FETCH:
                begin
                    if (!i_f_req && !i_mem_ack)
                    begin
                        state_q <= ARB_IDLE;
                    end
                end
                ARB_DATA:
                begin
                    if (!i_d_req && !i_mem_ack)
                    begin
                        state_q <= ARB_IDLE;
                    end
                end
                default:
                begin
                    state_q <= ARB_IDLE;
                end
            endcase
        end
    end

    assign o_mem_req = (f_grant && i_f_req) || (d_grant && i_d_req);
    assign o_mem     = f_grant ? i_f_pkt : i_d_pkt;
    assign o_f_ack   = f_grant && i_mem_ack;
    assign o_d_ack   = d_grant && i_mem_ack;
    assign o_rdata   = i_mem_rdata;

endmodule

/* hw/fetch_unit.sv */
module fetch_unit
(
    input  logic                      i_clk,
    input  logic                      i_arst_n,
    input  logic                      i_halt,
    input  logic                      i_take,
    input  logic                      i_redirect,
    input  logic [core_pkg::XLEN-1:0] i_redirect_pc,
    output logic                      o_instr_valid,
    output logic [core_pkg::XLEN-1:0] o_instr,
    output logic [core_pkg::XLEN-1:0] o_instr_pc,
    output logic                      o_req,
    output core_pkg::mem_req_t        o_pkt,
    input  logic                      i_ack,
    input  logic [core_pkg::XLEN-1:0] i_rdata
);
    import core_pkg::*;

    logic [XLEN-1:0] pc_q;          // next address to fetch.
    logic [XLEN-1:0] addr_q;
    logic [XLEN-1:0] buf_instr_q;
    logic [XLEN-1:0] buf_pc_q;
    logic            buf_valid_q;
    logic            req_q;
    logic            busy_q;
    logic            discard_q;
    logic            start;
    logic            ack_seen;
    logic            fill;

    // no new cycle on a take edge since the taken word may halt.
    assign start    = !busy_q && !i_halt && !i_take;
    assign ack_seen = busy_q && req_q && i_ack;
    assign fill     = ack_seen && !discard_q && !i_redirect && (!buf_valid_q || i_take);

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            pc_q        <= RESET_PC;
            buf_valid_q <= 1'b0;
            req_q       <= 1'b0;
            busy_q      <= 1'b0;
            discard_q   <= 1'b0;
        end
        else
        begin
            if (i_take || i_redirect)
            begin
                buf_valid_q <= 1'b0;
            end
            if (i_redirect)
            begin
                pc_q      <= i_redirect_pc;
                discard_q <= req_q;         // data in flight is stale.
            end
            if (start)
            begin
                req_q  <= 1'b1;
                busy_q <= 1'b1;
                pc_q   <= pc_q + XLEN'(4);
            end
            else if (ack_seen)
            begin
                req_q     <= 1'b0;
                discard_q <= 1'b0;
                if (fill)
                begin
                    buf_valid_q <= 1'b1;
                end
                else if (!discard_q && !i_redirect)
                begin
                    pc_q <= addr_q;         // buffer full so refetch later.
                end
            end
            else if (busy_q && !req_q && !i_ack)
            begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (start)
        begin
            addr_q <= pc_q;
        end
        if (fill)
        begin
            buf_instr_q <= i_rdata;
            buf_pc_q    <= addr_q;
        end
    end

    assign o_instr_valid = buf_valid_q;
    assign o_instr       = buf_instr_q;
    assign o_instr_pc    = buf_pc_q;
    assign o_req         = req_q;
    assign o_pkt         = '{we: 1'b0, addr: addr_q, wdata: '0};

endmodule

/* hw/decoder.sv */
module decoder
(
    input  logic [core_pkg::XLEN-1:0] i_instr,
    output core_pkg::dec_t            o_dec,
    output logic                      o_supported
);
    import core_pkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;

    assign opcode = i_instr[6:0];
    assign funct3 = i_instr[14:12];
    assign funct7 = i_instr[31:25];

    assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
    assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                    i_instr[11:8], 1'b0};
    assign imm_u = {i_instr[31:12], 12'b0};
    assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
                    i_instr[30:21], 1'b0};

    always_comb
    begin
        o_dec           = '0;
        o_dec.kind      = KIND_ALU;
        o_dec.alu_op    = ALU_ADD;
        o_dec.rd        = i_instr[11:7];
        o_dec.rs1       = i_instr[19:15];
        o_dec.rs2       = i_instr[24:20];
        o_supported     = 1'b0;
        case (opcode)
            OPC_OP:
            begin
                o_dec.writes_rd = 1'b1;
                o_supported     = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: o_dec.alu_op = ALU_ADD;
                    {7'b0100000, 3'b000}: o_dec.alu_op = ALU_SUB;
                    {7'b0000000, 3'b111}: o_dec.alu_op = ALU_AND;
                    {7'b0000000, 3'b110}: o_dec.alu_op = ALU_OR;
                    {7'b0000000, 3'b100}: o_dec.alu_op = ALU_XOR;
                    default:              o_supported  = 1'b0;
                endcase
            end
            OPC_OP_IMM:
            begin
                o_dec.use_imm   = 1'b1;
                o_dec.imm       = imm_i;
                o_dec.writes_rd = 1'b1;
                o_supported     = (funct3 == 3'b000);   // addi only.
            end
            OPC_LUI:
            begin
                o_dec.alu_op    = ALU_PASS;
                o_dec.use_imm   = 1'b1;
                o_dec.imm       = imm_u;
                o_dec.writes_rd = 1'b1;
                o_supported     = 1'b1;
            end
            OPC_LOAD:
            begin
                o_dec.kind      = KIND_LOAD;
                o_dec.imm       = imm_i;
                o_dec.writes_rd = 1'b1;
                o_supported     = (funct3 == 3'b010);   // lw only.
            end
            OPC_STORE:
            begin
                o_dec.kind  = KIND_STORE;
                o_dec.imm   = imm_s;
                o_supported = (funct3 == 3'b010);
            end
            OPC_BRANCH:
            begin
                o_dec.kind  = (funct3 == 3'b001) ? KIND_BNE : KIND_BEQ;
                o_dec.imm   = imm_b;
                o_supported = (funct3 == 3'b000) || (funct3 == 3'b001);
            end
            OPC_JAL:
            begin
                o_dec.kind      = KIND_JAL;
                o_dec.imm       = imm_j;
                o_dec.writes_rd = 1'b1;
                o_supported     = 1'b1;
            end
            default:
            begin
                o_supported = 1'b0;
            end
        endcase
    end

endmodule

/* hw/reg_file.sv */
module reg_file
(
    input  logic                        i_clk,
    input  logic                        i_arst_n,
    input  logic [core_pkg::REG_AW-1:0] i_rs1,
    input  logic [core_pkg::REG_AW-1:0] i_rs2,
    output logic [core_pkg::XLEN-1:0]   o_rdata1,
    output logic [core_pkg::XLEN-1:0]   o_rdata2,
    input  logic                        i_we,
    input  logic [core_pkg::REG_AW-1:0] i_rd,
    input  logic [core_pkg::XLEN-1:0]   i_wdata
);
    import core_pkg::*;

    logic [XLEN-1:0] regs_q [NUM_REGS];

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            for (int i = 0; i < NUM_REGS; i++)
            begin
                regs_q[i] <= '0;
            end
        end
        else if (i_we && (i_rd != '0))
        begin
            regs_q[i_rd] <= i_wdata;    // x0 stays zero.
        end
    end

    assign o_rdata1 = regs_q[i_rs1];
    assign o_rdata2 = regs_q[i_rs2];

endmodule

/* hw/exec_unit.sv */
module exec_unit
(
    input  logic                        i_clk,
    input  logic                        i_arst_n,
    input  logic                        i_instr_valid,
    input  logic [core_pkg::XLEN-1:0]   i_instr_pc,
    input  core_pkg::dec_t              i_dec,
    input  logic                        i_supported,
    output logic                        o_take,
    output logic                        o_redirect,
    output logic [core_pkg::XLEN-1:0]   o_redirect_pc,
    input  logic [core_pkg::XLEN-1:0]   i_rf_rdata1,
    input  logic [core_pkg::XLEN-1:0]   i_rf_rdata2,
    output logic                        o_rf_we,
    output logic [core_pkg::REG_AW-1:0] o_rf_rd,
    output logic [core_pkg::XLEN-1:0]   o_rf_wdata,
    output logic                        o_ls_start,
    output core_pkg::mem_req_t          o_ls_req,
    input  logic                        i_ls_done,
    input  logic [core_pkg::XLEN-1:0]   i_ls_rdata,
    output logic                        o_halt
);
    import core_pkg::*;

    typedef enum logic [1:0]
    {
        EX_READY,
        EX_WAIT,
        EX_HALT
    } ex_state_e;

    ex_state_e         state_q;
    logic              ld_we_q;
    logic [REG_AW-1:0] ld_rd_q;
    logic              fire;
    logic              is_mem;
    logic              taken;
    logic [XLEN-1:0]   op_b;
    logic [XLEN-1:0]   alu_res;
    logic [XLEN-1:0]   pc_plus4;
    logic [XLEN-1:0]   target;

    assign fire     = (state_q == EX_READY) && i_instr_valid;
    assign is_mem   = (i_dec.kind == KIND_LOAD) || (i_dec.kind == KIND_STORE);
    assign op_b     = i_dec.use_imm ? i_dec.imm : i_rf_rdata2;
    assign pc_plus4 = i_instr_pc + XLEN'(4);
    assign target   = i_instr_pc + i_dec.imm;

    always_comb
    begin
        case (i_dec.alu_op)
            ALU_SUB:  alu_res = i_rf_rdata1 - op_b;
            ALU_AND:  alu_res = i_rf_rdata1 & op_b;
            ALU_OR:   alu_res = i_rf_rdata1 | op_b;
            ALU_XOR:  alu_res = i_rf_rdata1 ^ op_b;
            ALU_PASS: alu_res = op_b;
            default:  alu_res = i_rf_rdata1 + op_b;
        endcase
    end

    assign taken = (i_dec.kind == KIND_JAL)
                || ((i_dec.kind == KIND_BEQ) && (i_rf_rdata1 == i_rf_rdata2))
                || ((i_dec.kind == KIND_BNE) && (i_rf_rdata1 != i_rf_rdata2));

    assign o_take        = fire;
    assign o_redirect    = fire && i_supported && taken && (target != pc_plus4);
    assign o_redirect_pc = target;
    assign o_ls_start    = fire && i_supported && is_mem;
    assign o_ls_req      = '{we: (i_dec.kind == KIND_STORE),
                             addr: i_rf_rdata1 + i_dec.imm,
                             wdata: i_rf_rdata2};

    always_comb
    begin
        if (state_q == EX_WAIT)
        begin
            o_rf_we    = i_ls_done && ld_we_q;  // load data lands here.
            o_rf_rd    = ld_rd_q;
            o_rf_wdata = i_ls_rdata;
        end
        else
        begin
            o_rf_we    = fire && i_supported && i_dec.writes_rd && !is_mem;
            o_rf_rd    = i_dec.rd;
            o_rf_wdata = (i_dec.kind == KIND_JAL) ? pc_plus4 : alu_res;
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            state_q <= EX_READY;
            ld_we_q <= 1'b0;
        end
        else
        begin
            case (state_q)
                EX_READY:
                begin
                    if (fire && !i_supported)
                    begin
                        state_q <= EX_HALT;
                    end
                    else if (o_ls_start)
                    begin
                        state_q <= EX_WAIT;
                        ld_we_q <= (i_dec.kind == KIND_LOAD);
                    end
                end
                EX_WAIT:
                begin
                    if (i_ls_done)
                    begin
                        state_q <= EX_READY;
                    end
                end
                default:
                begin
                    state_q <= EX_HALT;     // sticky until reset.
                end
            endcase
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (o_ls_start)
        begin
            ld_rd_q <= i_dec.rd;
        end
    end

    assign o_halt = (state_q == EX_HALT);

endmodule

/* hw/load_store_unit.sv */
module load_store_unit
(
    input  logic                      i_clk,
    input  logic                      i_arst_n,
    input  logic                      i_start,
    input  core_pkg::mem_req_t        i_req,
    output logic                      o_done,
    output logic [core_pkg::XLEN-1:0] o_rdata,
    output logic                      o_req,
    output core_pkg::mem_req_t        o_pkt,
    input  logic                      i_ack,
    input  logic [core_pkg::XLEN-1:0] i_rdata
);
    import core_pkg::*;

    mem_req_t        pkt_q;
    logic [XLEN-1:0] rdata_q;
    logic            req_q;
    logic            busy_q;
    logic            done_q;
    logic            accept;

    assign accept = i_start && !busy_q;

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            req_q  <= 1'b0;
            busy_q <= 1'b0;
            done_q <= 1'b0;
        end
        else
        begin
            done_q <= 1'b0;
            if (accept)
            begin
                req_q  <= 1'b1;
                busy_q <= 1'b1;
            end
            else if (req_q && i_ack)
            begin
                req_q <= 1'b0;
            end
            else if (busy_q && !req_q && !i_ack)
            begin
                busy_q <= 1'b0;
                done_q <= 1'b1;     // ack has fallen.
            end
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (accept)
        begin
            pkt_q <= i_req;
        end
        if (req_q && i_ack)
        begin
            rdata_q <= i_rdata;
        end
    end

    assign o_done  = done_q;
    assign o_rdata = rdata_q;
    assign o_req   = req_q;
    assign o_pkt   = pkt_q;

endmodule

/* hw/rv_core_top.sv */
module rv_core_top
(
    input  logic                      i_clk,
    input  logic                      i_arst_n,
    output logic                      o_mem_req,
    output core_pkg::mem_req_t        o_mem,
    input  logic                      i_mem_ack,
    input  logic [core_pkg::XLEN-1:0] i_mem_rdata,
    output logic                      o_halt
);
    import core_pkg::*;

    logic              instr_valid;
    logic [XLEN-1:0]   instr;
    logic [XLEN-1:0]   instr_pc;
    logic              take;
    logic              redirect;
    logic [XLEN-1:0]   redirect_pc;
    logic              f_req;
    mem_req_t          f_pkt;
    logic              f_ack;
    logic              d_req;
    mem_req_t          d_pkt;
    logic              d_ack;
    logic [XLEN-1:0]   bus_rdata;
    dec_t              dec;
    logic              supported;
    logic [XLEN-1:0]   rf_rdata1;
    logic [XLEN-1:0]   rf_rdata2;
    logic              rf_we;
    logic [REG_AW-1:0] rf_rd;
    logic [XLEN-1:0]   rf_wdata;
    logic              ls_start;
    mem_req_t          ls_req;
    logic              ls_done;
    logic [XLEN-1:0]   ls_rdata;

    fetch_unit fetch_i
    (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_halt         (o_halt),
        .i_take         (take),
        .i_redirect     (redirect),
        .i_redirect_pc  (redirect_pc),
        .o_instr_valid  (instr_valid),
        .o_instr        (instr),
        .o_instr_pc     (instr_pc),
        .o_req          (f_req),
        .o_pkt          (f_pkt),
        .i_ack          (f_ack),
        .i_rdata        (bus_rdata)
    );

    decoder decoder_i
    (
        .i_instr        (instr),
        .o_dec          (dec),
        .o_supported    (supported)
    );

    reg_file reg_file_i
    (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_rs1          (dec.rs1),
        .i_rs2          (dec.rs2),
        .o_rdata1       (rf_rdata1),
        .o_rdata2       (rf_rdata2),
        .i_we           (rf_we),
        .i_rd           (rf_rd),
        .i_wdata        (rf_wdata)
    );

    exec_unit exec_i
    (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_instr_valid  (instr_valid),
        .i_instr_pc     (instr_pc),
        .i_dec          (dec),
        .i_supported    (supported),
        .o_take         (take),
        .o_redirect     (redirect),
        .o_redirect_pc  (redirect_pc),
        .i_rf_rdata1    (rf_rdata1),
        .i_rf_rdata2    (rf_rdata2),
        .o_rf_we        (rf_we),
        .o_rf_rd        (rf_rd),
        .o_rf_wdata     (rf_wdata),
        .o_ls_start     (ls_start),
        .o_ls_req       (ls_req),
        .i_ls_done      (ls_done),
        .i_ls_rdata     (ls_rdata),
        .o_halt         (o_halt)
    );

    load_store_unit lsu_i
    (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_start        (ls_start),
        .i_req          (ls_req),
        .o_done         (ls_done),
        .o_rdata        (ls_rdata),
        .o_req          (d_req),
        .o_pkt          (d_pkt),
        .i_ack          (d_ack),
        .i_rdata        (bus_rdata)
    );

    mem_arbiter arbiter_i
    (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_f_req        (f_req),
        .i_f_pkt        (f_pkt),
        .o_f_ack        (f_ack),
        .i_d_req        (d_req),
        .i_d_pkt        (d_pkt),
        .o_d_ack        (d_ack),
        .o_rdata        (bus_rdata),
        .o_mem_req      (o_mem_req),
        .o_mem          (o_mem),
        .i_mem_ack      (i_mem_ack),
        .i_mem_rdata    (i_mem_rdata)
    );

endmodule

/* verif/core_props.sv */
module core_props
(
    input logic               i_clk,
    input logic               i_arst_n,
    input logic               o_mem_req,
    input core_pkg::mem_req_t o_mem,
    input logic               i_mem_ack,
    input logic               o_f_ack,
    input logic               o_d_ack
);
    timeunit 1ns;
    timeprecision 1ps;

    req_holds_until_ack: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_mem_req && !i_mem_ack |=> o_mem_req)
        else $error("bus request dropped before ack");

    payload_stable: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_mem_req |=> !o_mem_req || $stable(o_mem))
        else $error("bus payload changed while request high");

    ack_to_owner: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_mem_ack |-> (o_f_ack ^ o_d_ack))
        else $error("bus ack not routed to exactly one master");

    no_req_during_ack: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        $rose(o_mem_req) |-> !i_mem_ack)
        else $error("bus request rose while ack still high");

endmodule

bind mem_arbiter core_props props_i
(
    .i_clk     (i_clk),
    .i_arst_n  (i_arst_n),
    .o_mem_req (o_mem_req),
    .o_mem     (o_mem),
    .i_mem_ack (i_mem_ack),
    .o_f_ack   (o_f_ack),
    .o_d_ack   (o_d_ack)
);

/* verif/tb_core.sv */
module tb_core;
    timeunit 1ns;
    timeprecision 1ps;
    import core_pkg::*;

    typedef struct packed
    {
        logic [31:0] addr;
        logic [31:0] word;
    } mem_word_t;

    logic               i_clk;
    logic               i_arst_n;
    logic               i_mem_ack;
    logic [XLEN-1:0]    i_mem_rdata;
    logic               o_mem_req;
    mem_req_t           o_mem;
    logic               o_halt;

    logic [31:0]        mem [256];
    mem_word_t          prog_q [$];
    mem_word_t          exp_q [$];
    logic [31:0]        rng_state = 32'd23030;
    int                 errors = 0;
    int                 st_idx = 0;
    int                 delay = 0;
    bit                 pending = 0;
    bit                 first_seen = 0;
    bit                 prog_ready = 0;

    rv_core_top dut_i
    (
        .i_clk       (i_clk),
        .i_arst_n    (i_arst_n),
        .o_mem_req   (o_mem_req),
        .o_mem       (o_mem),
        .i_mem_ack   (i_mem_ack),
        .i_mem_rdata (i_mem_rdata),
        .o_halt      (o_halt)
    );

    always #20 i_clk = ~i_clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
        input logic [4:0] rd, input logic [6:0] opc);
        return {imm, rs1, 3'b000 | ((opc == OPC_LOAD) ? 3'b010 : 3'b000), rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
        input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    task automatic put(input logic [31:0] a, input logic [31:0] w);
        prog_q.push_back('{addr: a, word: w});
    endtask

    task automatic expect_store(input logic [31:0] a, input logic [31:0] d);
        exp_q.push_back('{addr: a, word: d});
    endtask

    // four-phase memory model with random ack delay.
    always @(posedge i_clk)
    begin
        if (!i_arst_n)
        begin
            i_mem_ack <= 1'b0;
            pending = 0;
        end
        else if (i_mem_ack)
        begin
            if (!o_mem_req)
            begin
                i_mem_ack <= 1'b0;
            end
        end
        else if (o_mem_req)
        begin
            if (!first_seen)
            begin
                first_seen = 1;
                assert (o_mem.addr == RESET_PC)
                else
                begin
                    errors++;
                    $display("[FAIL] o_mem.addr first fetch got %h expected %h",
                             o_mem.addr, RESET_PC);
                end
            end
            if (!pending)
            begin
                pending = 1;
                rng_state = xorshift(rng_state);
                delay = int'(rng_state % 32'd4);
            end
            if (delay == 0)
            begin
                pending = 0;
                i_mem_ack   <= 1'b1;
                i_mem_rdata <= mem[o_mem.addr[9:2]];
                if (o_mem.we)
                begin
                    mem[o_mem.addr[9:2]] = o_mem.wdata;
                    check_store();
                end
            end
            else
            begin
                delay--;
            end
        end
    end

    task automatic check_store();
        if (st_idx >= exp_q.size())
        begin
            errors++;
            $display("unexpected extra store to address %h", o_mem.addr);
        end
        else
        begin
            assert (o_mem.addr == exp_q[st_idx].addr)
            else
            begin
                errors++;
                $display("[FAIL] o_mem.addr got %h expected %h",
                         o_mem.addr, exp_q[st_idx].addr);
            end
            assert (o_mem.wdata == exp_q[st_idx].word)
            else
            begin
                errors++;
                $display("[FAIL] o_mem.wdata got %h expected %h",
                         o_mem.wdata, exp_q[st_idx].word);
            end
            st_idx++;
        end
    endtask

    initial
    begin
        i_clk       = 1'b0;
        i_arst_n    = 1'b0;
        i_mem_ack   = 1'b0;
        i_mem_rdata = '0;

        put(32'h00, {20'h12345, 5'd1, OPC_LUI});                 // x1 = 0x12345000.
        put(32'h04, i_type(12'h0F0, 5'd0, 5'd2, OPC_OP_IMM));
        put(32'h08, i_type(12'hFFF, 5'd0, 5'd3, OPC_OP_IMM));    // x3 = -1.
        put(32'h0C, r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd4));    // add.
        put(32'h10, r_type(7'h20, 5'd3, 5'd2, 3'b000, 5'd5));    // sub.
        put(32'h14, r_type(7'h00, 5'd3, 5'd1, 3'b111, 5'd6));    // and.
        put(32'h18, r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd7));    // or.
        put(32'h1C, r_type(7'h00, 5'd3, 5'd1, 3'b100, 5'd8));    // xor.
        put(32'h20, i_type(12'h200, 5'd0, 5'd10, OPC_OP_IMM));
        for (int r = 1; r <= 8; r++)
        begin
            put(32'h24 + 32'(4 * (r - 1)), s_type(12'(4 * (r - 1)), 5'(r), 5'd10));
        end
        put(32'h44, i_type(12'h100, 5'd0, 5'd11, OPC_LOAD));
        put(32'h48, i_type(12'h123, 5'd11, 5'd12, OPC_OP_IMM)); // uses load right away.
        put(32'h4C, s_type(12'd32, 5'd12, 5'd10));
        put(32'h50, b_type(13'd8, 5'd3, 5'd2, 3'b000));          // beq not taken.
        put(32'h54, s_type(12'd36, 5'd2, 5'd10));
        put(32'h58, b_type(13'd8, 5'd7, 5'd4, 3'b000));          // beq taken.
        put(32'h5C, s_type(12'd40, 5'd3, 5'd10));
        put(32'h60, b_type(13'd8, 5'd2, 5'd2, 3'b001));          // bne not taken.
        put(32'h64, s_type(12'd44, 5'd5, 5'd10));
        put(32'h68, b_type(13'd8, 5'd2, 5'd1, 3'b001));          // bne taken.
        put(32'h6C, s_type(12'd48, 5'd3, 5'd10));
        put(32'h70, j_type(21'd8, 5'd13));
        put(32'h74, s_type(12'd52, 5'd3, 5'd10));
        put(32'h78, s_type(12'd56, 5'd13, 5'd10));
        put(32'h7C, 32'h0000_0000);                              // halts the core.
        put(32'h100, 32'hCAFE_0000);

        expect_store(32'h200, 32'h1234_5000);
        expect_store(32'h204, 32'h0000_00F0);
        expect_store(32'h208, 32'hFFFF_FFFF);
        expect_store(32'h20C, 32'h1234_50F0);
        expect_store(32'h210, 32'h0000_00F1);
        expect_store(32'h214, 32'h1234_5000);
        expect_store(32'h218, 32'h1234_50F0);
        expect_store(32'h21C, 32'hEDCB_AFFF);
        expect_store(32'h220, 32'hCAFE_0123);
        expect_store(32'h224, 32'h0000_00F0);
        expect_store(32'h22C, 32'h0000_00F1);
        expect_store(32'h238, 32'h0000_0074);                    // jal link.

        for (int i = 0; i < 256; i++)
        begin
            mem[i] = 32'hDEAD_0000 ^ 32'(i * 4);
        end
        foreach (prog_q[i])
        begin
            mem[prog_q[i].addr[9:2]] = prog_q[i].word;
        end
        prog_ready = 1;

        repeat (3) @(posedge i_clk);
        i_arst_n <= 1'b1;
        @(negedge i_clk);
        assert (!o_mem_req && !o_halt)
        else
        begin
            errors++;
            $display("request or halt high right after reset");
        end

        wait (o_halt);
        @(negedge i_clk);
        while (o_mem_req || i_mem_ack)
        begin
            @(negedge i_clk);
        end
        repeat (20)
        begin
            @(negedge i_clk);
            assert (!o_mem_req)
            else
            begin
                errors++;
                $display("new bus request after halt");
            end
        end
        assert (st_idx == exp_q.size())
        else
        begin
            errors++;
            $display("only %0d of %0d expected stores seen", st_idx, exp_q.size());
        end

        $display("errors: %0d, stores seen: %0d", errors, st_idx);
        if (errors == 0)
        begin
            $display(">>> PASS");
        end
        else
        begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // watchdog allows 20 cycles per program word.
    initial
    begin
        wait (prog_ready);
        #(prog_q.size() * 20 * 40);
        $display("timeout: the core did not halt in time");
        $display(">>> FAIL");
        $finish;
    end

endmodule

/* all.f */
hw/core_pkg.sv
hw/mem_arbiter.sv
hw/fetch_unit.sv
hw/decoder.sv
hw/reg_file.sv
hw/exec_unit.sv
hw/load_store_unit.sv
hw/rv_core_top.sv
verif/core_props.sv
verif/tb_core.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_core
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
